// File: vlog.f
rtl/lpe_data_pkg.sv
rtl/lpe_ctrl_pkg.sv
rtl/lpe_operand_buf.sv
rtl/lpe_ctrl_fsm.sv
rtl/lpe_pair_counter.sv
rtl/lpe_mac.sv
rtl/lpe_top.sv
sim/lpe_top_chk.sv
sim/lpe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lpe_tb -f vlog.f -o lpe_sim \
  && ./obj_dir/lpe_sim \
  || exit 1

// File: sim/lpe_tb.sv
`timescale 1ns/100ps

module lpe_tb;

  // Four cycles per pair, plus reset, skew, hold and flush cycles, plus margin
  localparam int TOTAL_PAIRS    = 5 + 6 + 7 + 7 + 300 + 24;
  localparam int STALL_CYCLES   = 16 + 10 + 10 + 4;
  localparam int TIMEOUT_CYCLES = TOTAL_PAIRS * 4 + STALL_CYCLES + 200;

  logic                   clk;
  logic                   rst;
  logic                   l_valid;
  logic                   l_last;
  lpe_data_pkg::operand_t l_data;
  logic                   l_ready;
  logic                   t_valid;
  logic                   t_last;
  lpe_data_pkg::operand_t t_data;
  logic                   t_ready;
  logic                   res_valid;
  logic                   res_ready;
  lpe_data_pkg::acc_t     res_data;
  lpe_data_pkg::count_t   res_count;
  logic                   err_unaligned;

  // Current batch, one entry per pair
  lpe_data_pkg::operand_t l_ops[$];
  lpe_data_pkg::operand_t t_ops[$];
  logic                   l_lasts[$];
  logic                   t_lasts[$];

  // Reference model of the batch being built
  int model_sum;
  int model_pairs;

  int cycle_count;
  int res_cycle;
  int err_pulses;
  // Index 1 is the left stream, index 0 the top stream
  int stalls[2];
  int last_cycle[2];

  lpe_top i_lpe_top (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("SOME TESTS FAILED");
        $fatal(1, "Run timed out after %0d cycles before the tests finished", cycle_count);
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && err_unaligned) begin
      err_pulses++;
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: actual 0x%0h expected 0x%0h", name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Check of %s failed", name);
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic add_pair(input logic l_end, input logic t_end);
    lpe_data_pkg::operand_t a;
    lpe_data_pkg::operand_t b;
    a = lpe_data_pkg::operand_t'($urandom);
    b = lpe_data_pkg::operand_t'($urandom);
    l_ops.push_back(a);
    t_ops.push_back(b);
    l_lasts.push_back(l_end);
    t_lasts.push_back(t_end);
    model_sum += int'(a) * int'(b);
    model_pairs++;
  endtask

  task automatic new_batch(input int n);
    l_ops.delete();
    t_ops.delete();
    l_lasts.delete();
    t_lasts.delete();
    model_sum   = 0;
    model_pairs = 0;
    for (int i = 0; i < n; i++) begin
      add_pair(i == n - 1, i == n - 1);
    end
  endtask

  // Sum wraps at 24 bits
  function automatic lpe_data_pkg::acc_t model_acc();
    return lpe_data_pkg::acc_t'(model_sum);
  endfunction

  function automatic lpe_data_pkg::count_t model_count();
    if (model_pairs > 255) begin
      return 8'd255;
    end
    return lpe_data_pkg::count_t'(model_pairs);
  endfunction

  // Offers one stream's operands, each held until it is taken
  task automatic drive_stream(input bit left, input int start_delay);
    logic taken;
    repeat (start_delay) next_cycle();
    for (int i = 0; i < l_ops.size(); i++) begin
      if (left) begin
        l_valid = 1'b1;
        l_data  = l_ops[i];
        l_last  = l_lasts[i];
      end else begin
        t_valid = 1'b1;
        t_data  = t_ops[i];
        t_last  = t_lasts[i];
      end
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = left ? l_ready : t_ready;
        if (!taken) begin
          stalls[left]++;
        end else if (left ? l_lasts[i] : t_lasts[i]) begin
          last_cycle[left] = cycle_count;
        end
        next_cycle();
      end
    end
    if (left) begin
      l_valid = 1'b0;
      l_last  = 1'b0;
    end else begin
      t_valid = 1'b0;
      t_last  = 1'b0;
    end
  endtask

  task automatic send_batch(input int l_delay, input int t_delay);
    fork
      drive_stream(1'b1, l_delay);
      drive_stream(1'b0, t_delay);
    join
  endtask

  task automatic wait_result();
    @(negedge clk);
    while (!res_valid) begin
      @(negedge clk);
    end
    res_cycle = cycle_count;
  endtask

  // Checks the result, then keeps res_ready low for stall cycles
  task automatic expect_result(input lpe_data_pkg::acc_t exp_acc,
                               input lpe_data_pkg::count_t exp_count, input int stall);
    wait_result();
    check("res_data", 32'(res_data), 32'(exp_acc));
    check("res_count", 32'(res_count), 32'(exp_count));
    repeat (stall) begin
      next_cycle();
      @(negedge clk);
      check("res_valid", 32'(res_valid), 32'd1);
      check("res_data", 32'(res_data), 32'(exp_acc));
      check("res_count", 32'(res_count), 32'(exp_count));
    end
    next_cycle();
    if (!res_ready) begin
      res_ready = 1'b1;
      next_cycle();
    end
  endtask

  task automatic wait_error();
    @(negedge clk);
    while (!err_unaligned) begin
      check("res_valid", 32'(res_valid), 32'd0);
      @(negedge clk);
    end
    next_cycle();
  endtask

  task automatic test_aligned();
    new_batch(5);
    send_batch(0, 0);
    expect_result(model_acc(), model_count(), 0);
    check("last_cycle_skew", 32'(last_cycle[1] - last_cycle[0]), 32'd0);
    check("res_latency", 32'(res_cycle - last_cycle[1]), 32'd2);
  endtask

  // Top stream starts only after the left one has stalled
  task automatic test_skewed();
    stalls = '{0, 0};
    new_batch(6);
    send_batch(0, 10);
    expect_result(model_acc(), model_count(), 0);
    check("l_ready_low_seen", 32'(stalls[1] > 0), 32'd1);
  endtask

  task automatic test_backpressure();
    lpe_data_pkg::acc_t   first_acc;
    lpe_data_pkg::count_t first_count;
    int                   hold;
    hold      = $urandom_range(10, 3);
    res_ready = 1'b0;
    new_batch(4);
    send_batch(0, 0);
    first_acc   = model_acc();
    first_count = model_count();
    stalls      = '{0, 0};
    // Next batch fills both buffers while the result is held
    new_batch(3);
    fork
      expect_result(first_acc, first_count, hold);
      send_batch(0, 0);
    join
    check("l_ready_low_seen", 32'(stalls[1] > 0), 32'd1);
    check("t_ready_low_seen", 32'(stalls[0] > 0), 32'd1);
    expect_result(model_acc(), model_count(), 0);
  endtask

  task automatic test_unaligned();
    err_pulses = 0;
    new_batch(0);
    add_pair(1'b0, 1'b0);
    add_pair(1'b0, 1'b0);
    add_pair(1'b1, 1'b0);
    send_batch(0, 0);
    wait_error();
    new_batch(4);
    send_batch(0, 0);
    expect_result(model_acc(), model_count(), 0);
    check("err_pulses", 32'(err_pulses), 32'd1);
  endtask

  task automatic test_saturation();
    new_batch(300);
    send_batch(0, 0);
    expect_result(model_acc(), model_count(), 0);
  endtask

  task automatic test_back_to_back();
    int n;
    for (int b = 0; b < 3; b++) begin
      n = (b == 1) ? 1 : $urandom_range(8, 1);
      new_batch(n);
      send_batch(0, 0);
      expect_result(model_acc(), model_count(), 0);
    end
  endtask

  initial begin
    void'($urandom(32'h89a2));
    rst       = 1'b1;
    l_valid   = 1'b0;
    l_last    = 1'b0;
    l_data    = '0;
    t_valid   = 1'b0;
    t_last    = 1'b0;
    t_data    = '0;
    res_ready = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    next_cycle();
    test_aligned();
    test_skewed();
    test_backpressure();
    test_unaligned();
    test_saturation();
    test_back_to_back();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: sim/lpe_top_chk.sv
`timescale 1ns/100ps

module lpe_top_chk (
  input logic                 clk,
  input logic                 rst,
  input logic                 l_ready,
  input logic                 res_valid,
  input logic                 res_ready,
  input lpe_data_pkg::acc_t   res_data,
  input lpe_data_pkg::count_t res_count,
  input logic                 err_unaligned
);

  // A held result stays put until the sink takes it
  res_hold_a: assert property (@(posedge clk) disable iff (rst)
    (res_valid && !res_ready) |=> (res_valid && $stable(res_data) && $stable(res_count)))
    else $error("Result changed while the sink stalled it");

  // Error flush is a single cycle
  err_pulse_a: assert property (@(posedge clk) disable iff (rst)
    err_unaligned |=> !err_unaligned)
    else $error("err_unaligned high for two cycles in a row");

  res_err_excl_a: assert property (@(posedge clk) disable iff (rst)
    !(res_valid && err_unaligned))
    else $error("res_valid and err_unaligned high together");

  // Buffers are empty right after reset
  ready_after_rst_a: assert property (@(posedge clk) $fell(rst) |-> l_ready)
    else $error("l_ready low in the cycle after reset release");

endmodule

bind lpe_top lpe_top_chk i_chk (
  .clk           (clk),
  .rst           (rst),
  .l_ready       (l_ready),
  .res_valid     (res_valid),
  .res_ready     (res_ready),
  .res_data      (res_data),
  .res_count     (res_count),
  .err_unaligned (err_unaligned)
);

// File: rtl/lpe_top.sv
`timescale 1ns/100ps

module lpe_top (
  input  logic                   clk,
  input  logic                   rst,

  // Left operand stream
  input  logic                   l_valid,
  input  logic                   l_last,
  input  lpe_data_pkg::operand_t l_data,
  output logic                   l_ready,

  // Top operand stream
  input  logic                   t_valid,
  input  logic                   t_last,
  input  lpe_data_pkg::operand_t t_data,
  output logic                   t_ready,

  // Result stream
  output logic                   res_valid,
  input  logic                   res_ready,
  output lpe_data_pkg::acc_t     res_data,
  output lpe_data_pkg::count_t   res_count,

  // Unaligned last flags
  output logic                   err_unaligned
);

  logic                   l_buf_valid;
  lpe_data_pkg::operand_t l_buf_data;
  logic                   l_buf_last;

  logic                   t_buf_valid;
  lpe_data_pkg::operand_t t_buf_data;
  logic                   t_buf_last;

  logic                   pop;
  logic                   clear;

  // Left holding buffer
  lpe_operand_buf i_l_buf (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (l_valid),
    .in_ready  (l_ready),
    .in_data   (l_data),
    .in_last   (l_last),
    .pop       (pop),
    .buf_valid (l_buf_valid),
    .buf_data  (l_buf_data),
    .buf_last  (l_buf_last)
  );

  // Top holding buffer
  lpe_operand_buf i_t_buf (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (t_valid),
    .in_ready  (t_ready),
    .in_data   (t_data),
    .in_last   (t_last),
    .pop       (pop),
    .buf_valid (t_buf_valid),
    .buf_data  (t_buf_data),
    .buf_last  (t_buf_last)
  );

  lpe_ctrl_fsm i_fsm (
    .clk           (clk),
    .rst           (rst),
    .l_buf_valid   (l_buf_valid),
    .l_buf_last    (l_buf_last),
    .t_buf_valid   (t_buf_valid),
    .t_buf_last    (t_buf_last),
    .res_ready     (res_ready),
    .pop           (pop),
    .clear         (clear),
    .res_valid     (res_valid),
    .err_unaligned (err_unaligned)
  );

  // Pair count goes out with the result
  lpe_pair_counter i_counter (
    .clk   (clk),
    .rst   (rst),
    .inc   (pop),
    .clear (clear),
    .count (res_count)
  );

  lpe_mac i_mac (
    .clk    (clk),
    .rst    (rst),
    .acc_en (pop),
    .clear  (clear),
    .a      (l_buf_data),
    .b      (t_buf_data),
    .acc    (res_data)
  );

endmodule

// File: rtl/lpe_mac.sv
`timescale 1ns/100ps

module lpe_mac (
  input  logic                   clk,
  input  logic                   rst,

  // Accumulate on a consumed pair
  input  logic                   acc_en,
  // Zero the partial sum
  input  logic                   clear,

  // Operands from the left and top buffers
  input  lpe_data_pkg::operand_t a,
  input  lpe_data_pkg::operand_t b,

  output lpe_data_pkg::acc_t     acc
);

  logic signed [2*lpe_data_pkg::OPERAND_W-1:0] product;
  lpe_data_pkg::acc_t                          product_ext;
  lpe_data_pkg::acc_t                          acc_q;

  // Full precision signed product
  assign product = a * b;

  // Sign extension up to accumulator width
  assign product_ext = lpe_data_pkg::acc_t'(product);

  // Sum wraps at the accumulator width
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      acc_q <= '0;
    end else if (acc_en) begin
      acc_q <= acc_q + product_ext;
    end
  end

  assign acc = acc_q;

endmodule

// File: rtl/lpe_pair_counter.sv
`timescale 1ns/100ps

module lpe_pair_counter (
  input  logic                 clk,
  input  logic                 rst,

  // One increment per consumed pair
  input  logic                 inc,
  // Start of a new batch
  input  logic                 clear,

  output lpe_data_pkg::count_t count
);

  lpe_data_pkg::count_t count_q;
  logic                 at_max;

  // No further counting once the saturation limit is reached
  assign at_max = (count_q == lpe_data_pkg::count_t'(lpe_data_pkg::COUNT_MAX));

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      count_q <= '0;
    end else if (inc && !at_max) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count = count_q;

endmodule

// File: rtl/lpe_ctrl_fsm.sv
`timescale 1ns/100ps

module lpe_ctrl_fsm (
  input  logic clk,
  input  logic rst,

  // Status of the two operand buffers
  input  logic l_buf_valid,
  input  logic l_buf_last,
  input  logic t_buf_valid,
  input  logic t_buf_last,

  // Sink side of the result stream
  input  logic res_ready,

  // Datapath controls
  output logic pop,
  output logic clear,

  // Result and error status
  output logic res_valid,
  output logic err_unaligned
);

  lpe_ctrl_pkg::lpe_state_e state;
  lpe_ctrl_pkg::lpe_state_e state_next;

  logic accepting;
  logic pair_present;
  logic both_last;
  logic one_last;
  logic res_done;

  // Pairs are only consumed while a batch can still grow
  assign accepting = (state == lpe_ctrl_pkg::ST_IDLE) ||
                     (state == lpe_ctrl_pkg::ST_MAC);

  assign pair_present = accepting && l_buf_valid && t_buf_valid;

  // Classification of the pair at the head of both buffers
  assign both_last = l_buf_last && t_buf_last;
  assign one_last  = l_buf_last ^ t_buf_last;

  // Result handshake completes
  assign res_done = (state == lpe_ctrl_pkg::ST_END) && res_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= lpe_ctrl_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      lpe_ctrl_pkg::ST_IDLE,
      lpe_ctrl_pkg::ST_MAC: begin
        if (pair_present) begin
          if (both_last) begin
            state_next = lpe_ctrl_pkg::ST_END;
          end else if (one_last) begin
            state_next = lpe_ctrl_pkg::ST_ERR;
          end else begin
            state_next = lpe_ctrl_pkg::ST_MAC;
          end
        end
      end
      lpe_ctrl_pkg::ST_END: begin
        // A new batch never starts on the handshake cycle
        if (res_ready) begin
          state_next = lpe_ctrl_pkg::ST_IDLE;
        end
      end
      lpe_ctrl_pkg::ST_ERR: begin
        state_next = lpe_ctrl_pkg::ST_IDLE;
      end
      default: begin
        state_next = lpe_ctrl_pkg::ST_IDLE;
      end
    endcase
  end

  // One pop drains both buffers and feeds MAC and counter
  assign pop = pair_present;

  // Sum and count restart after a delivered result or a flush
  assign clear = res_done || (state == lpe_ctrl_pkg::ST_ERR);

  assign res_valid     = (state == lpe_ctrl_pkg::ST_END);
  assign err_unaligned = (state == lpe_ctrl_pkg::ST_ERR);

endmodule

// File: rtl/lpe_operand_buf.sv
`timescale 1ns/100ps

module lpe_operand_buf (
  input  logic                   clk,
  input  logic                   rst,

  // Operand stream from the source
  input  logic                   in_valid,
  output logic                   in_ready,
  input  lpe_data_pkg::operand_t in_data,
  input  logic                   in_last,

  // Held operand towards the FSM and the MAC
  input  logic                   pop,
  output logic                   buf_valid,
  output lpe_data_pkg::operand_t buf_data,
  output logic                   buf_last
);

  logic                   full;
  logic                   accept;
  lpe_data_pkg::operand_t data_q;
  logic                   last_q;

  // Free slot now, or the slot is vacated in this very cycle
  assign in_ready = !full || pop;
  assign accept   = in_valid && in_ready;

  // Occupancy bit
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (pop) begin
      full <= 1'b0;
    end
  end

  // Payload is loaded only on an accepted transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      data_q <= in_data;
      last_q <= in_last;
    end
  end

  assign buf_valid = full;
  assign buf_data  = data_q;
  assign buf_last  = last_q;

endmodule

// File: rtl/lpe_ctrl_pkg.sv
package lpe_ctrl_pkg;

  // Width of the control state encoding
  localparam int STATE_W = 2;

  // Control states of the processing element
  typedef enum logic [STATE_W-1:0] {
    // Waiting for the first pair of a batch
    ST_IDLE = 2'd0,
    // Batch in progress
    ST_MAC  = 2'd1,
    // Result held until the sink takes it
    ST_END  = 2'd2,
    // One-cycle flush after an unaligned last flag
    ST_ERR  = 2'd3
  } lpe_state_e;

endpackage

// File: rtl/lpe_data_pkg.sv
package lpe_data_pkg;

  // Signed operand width on the left and top streams
  localparam int OPERAND_W = 8;

  // The sum wraps at this accumulator width
  localparam int ACC_W = 24;

  // Pair count width and its saturation value
  localparam int COUNT_W   = 8;
  localparam int COUNT_MAX = 255;

  typedef logic signed [OPERAND_W-1:0] operand_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  typedef logic [COUNT_W-1:0] count_t;

endpackage
